// File: tb.f
rtl/isaPkg.sv
rtl/ctrlPkg.sv
rtl/control.sv
rtl/aluControl.sv
rtl/regFileBypass.sv
rtl/decode.sv
bench/clockGen.sv
bench/decodeChecker.sv
bench/tbDecode.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tbDecode
FILELIST = tb.f

.PHONY: run clean

run:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Verification passed"

clean:
	rm -rf obj_dir

// File: bench/tbDecode.sv
// ==========================================================================
// Testbench for the decode stage
// Random stimulus from an LCG, DUT instance and the output checker
// ==========================================================================
`default_nettype none
`timescale 1ns/100ps

module tbDecode;

    import isaPkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int CTRL_CYCLES  = 200;
    localparam int RF_CYCLES    = 200;
    localparam int BR_CYCLES    = 120;
    localparam int NOP_CYCLES   = 120;
    localparam int CYCLE_LIMIT  = 8 + RESET_CYCLES + CTRL_CYCLES + RF_CYCLES
                                  + BR_CYCLES + NOP_CYCLES + 50;

    logic        clk, rst;
    logic [15:0] instr, WB, PC;
    logic        NOP_mech, IDF_err, DMWB_RegWrt, BrchCnd;
    logic [2:0]  DMWB_RD;
    logic [3:0]  IDEX_BranchTaken;
    logic        nHaltSig, MemRead, MemWrt, RegWrt, ALUJmp, ImmSrc, ALUSign;
    logic        invA, invB, Cin, NOP, NOP_Branch, valid, err;
    logic [1:0]  RegSrc, BSrc;
    logic [3:0]  BranchTaken, Oper;
    logic [15:0] RSData, RTData, Imm5, Imm8, sImm11, PC_Next;
    logic [2:0]  Rs, Rt, RD;
    logic [2:0]  testId;
    logic [31:0] seed;
    int          errCount, checkCount, cycles;

    clockGen      u_clockGen (.*);
    decode        u_decode (.*);
    decodeChecker u_checker (.*);

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic logic [4:0] legalOpcode(input logic [31:0] r);
        case (r[31:16] % 12)
            0:       return OP_HALT;
            1:       return OP_NOP;
            2:       return OP_J;
            3:       return OP_JAL;
            4:       return OP_ADDI;
            5:       return OP_SUBI;
            6:       return OP_XORI;
            7:       return OP_ANDNI;
            8:       return OP_BEQZ;
            9:       return OP_ST;
            10:      return OP_LD;
            default: return OP_RALU;
        endcase
    endfunction

    // One cycle of random inputs; rs and rt often hit the write register
    task automatic randomCycle(input logic [2:0] id, input bit anyOp,
                               input bit useBranch, input bit useHazard);
        logic [31:0] r1, r2, r3, r4;
        logic [15:0] word;
        seed = lcgNext(seed);
        r1   = seed;
        seed = lcgNext(seed);
        r2   = seed;
        seed = lcgNext(seed);
        r3   = seed;
        seed = lcgNext(seed);
        r4   = seed;
        word = {anyOp ? r1[31:27] : legalOpcode(r1), r2[31:21]};
        if (r4[20:19] == 2'b00) begin
            word[10:8] = r3[15:13];
        end
        if (r4[18:17] == 2'b00) begin
            word[7:5] = r3[15:13];
        end
        @(posedge clk);
        testId           <= id;
        instr            <= word;
        PC               <= r2[20:5];
        WB               <= r3[31:16];
        DMWB_RD          <= r3[15:13];
        DMWB_RegWrt      <= r4[22] | r4[21];
        BrchCnd          <= useBranch ? r4[31] : 1'b0;
        IDEX_BranchTaken <= useBranch ? r4[30:27] : 4'b0000;
        NOP_mech         <= useHazard ? (r4[26:25] == 2'b00) : 1'b0;
        IDF_err          <= useHazard ? (r4[24:23] == 2'b00) : 1'b0;
    endtask

    initial begin
        instr            = '0;
        WB               = '0;
        PC               = '0;
        NOP_mech         = 1'b0;
        IDF_err          = 1'b0;
        DMWB_RD          = '0;
        DMWB_RegWrt      = 1'b0;
        BrchCnd          = 1'b0;
        IDEX_BranchTaken = '0;
        testId           = 3'd0;
        seed             = 32'hc136;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
        end
        // Registers read back as zero after reset
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            instr <= {OP_NOP, 3'(i), 3'(7 - i), 5'd0};
        end
        repeat (CTRL_CYCLES) randomCycle(3'd1, 1'b0, 1'b0, 1'b0);
        repeat (RF_CYCLES) randomCycle(3'd2, 1'b0, 1'b0, 1'b0);
        repeat (BR_CYCLES) randomCycle(3'd3, 1'b0, 1'b1, 1'b0);
        repeat (NOP_CYCLES) randomCycle(3'd4, 1'b1, 1'b0, 1'b1);
        // Let the checker finish its last falling-edge compare
        @(posedge clk);
        @(posedge clk);
        $display("Checks: %0d, errors: %0d", checkCount, errCount);
        if (errCount == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Verification failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/decodeChecker.sv
// ==========================================================================
// Decode stage checker
// Reference model of the stage with a register shadow; compares every
// DUT output on the falling edge and counts checks and errors
// ==========================================================================
`default_nettype none
`timescale 1ns/100ps

module decodeChecker (
    input  wire         clk,
    input  wire         rst,
    input  wire  [2:0]  testId,
    input  wire  [15:0] instr,
    input  wire  [15:0] WB,
    input  wire  [15:0] PC,
    input  wire         NOP_mech,
    input  wire         IDF_err,
    input  wire  [2:0]  DMWB_RD,
    input  wire         DMWB_RegWrt,
    input  wire         BrchCnd,
    input  wire  [3:0]  IDEX_BranchTaken,
    input  wire         nHaltSig,
    input  wire         MemRead,
    input  wire         MemWrt,
    input  wire         RegWrt,
    input  wire         ALUJmp,
    input  wire         ImmSrc,
    input  wire         ALUSign,
    input  wire  [1:0]  RegSrc,
    input  wire  [1:0]  BSrc,
    input  wire  [3:0]  BranchTaken,
    input  wire  [3:0]  Oper,
    input  wire         invA,
    input  wire         invB,
    input  wire         Cin,
    input  wire  [15:0] RSData,
    input  wire  [15:0] RTData,
    input  wire  [2:0]  Rs,
    input  wire  [2:0]  Rt,
    input  wire  [2:0]  RD,
    input  wire  [15:0] Imm5,
    input  wire  [15:0] Imm8,
    input  wire  [15:0] sImm11,
    input  wire  [15:0] PC_Next,
    input  wire         NOP,
    input  wire         NOP_Branch,
    input  wire         valid,
    input  wire         err,
    output int          errCount,
    output int          checkCount
);

    import isaPkg::*;
    import ctrlPkg::*;

    logic [15:0] shadow [8];
    logic        expValid;
    logic        started;

    initial begin
        errCount   = 0;
        checkCount = 0;
        started    = 1'b0;
    end

    function automatic string testName(input logic [2:0] id);
        case (id)
            3'd0:    return "reset";
            3'd1:    return "control";
            3'd2:    return "regfile";
            3'd3:    return "branchCancel";
            3'd4:    return "nopAndErr";
            default: return "unknown";
        endcase
    endfunction

    task automatic checkVal(input string field, input logic [15:0] expVal,
                            input logic [15:0] actVal);
        checkCount++;
        if (actVal !== expVal) begin
            errCount++;
            $display("Error %s: %s expected %h actual %h",
                     testName(testId), field, expVal, actVal);
        end
    endtask

    // Shadow of the register file, updated like the write port
    always @(posedge clk) begin
        started  <= 1'b1;
        expValid <= !rst;
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                shadow[i] <= 16'h0000;
            end
        end else if (DMWB_RegWrt) begin
            shadow[DMWB_RD] <= WB;
        end
    end

    task automatic checkOutputs();
        logic [4:0]  op;
        logic [1:0]  fn;
        logic        useFn;
        logic        eRegWrt, eMemWrt, eMemRead, eJmp, eHalt, eNop;
        logic        eZext, eImmSrc, eSign, eIll, eBt, eInvA, eInvB, eCin;
        logic [1:0]  eDst, eBSrc, eRegSrc;
        logic [3:0]  eBr, eOper;
        logic [2:0]  eRd;
        logic [15:0] eImm5, eImm8, eImm11, eRs, eRt;
        op = NOP_mech ? OP_NOP : instr[15:11];
        fn = instr[1:0];
        {useFn, eRegWrt, eMemWrt, eMemRead, eJmp, eNop} = '0;
        {eZext, eImmSrc, eSign, eIll, eInvA, eInvB, eCin} = '0;
        eHalt   = 1'b1;
        eDst    = DST_RT;
        eBSrc   = BSRC_REG;
        eRegSrc = WB_ALU;
        eBr     = 4'b0000;
        eOper   = ALU_PASS;
        case (op)
            OP_HALT: eHalt = 1'b0;
            OP_NOP:  eNop = 1'b1;
            OP_J, OP_JAL: begin
                eJmp    = 1'b1;
                eImmSrc = 1'b1;
                eBSrc   = BSRC_IMM11;
                eBr     = 4'b1000;
                if (op == OP_JAL) begin
                    eRegWrt = 1'b1;
                    eDst    = DST_R7;
                    eRegSrc = WB_PC;
                end
            end
            OP_ADDI, OP_SUBI, OP_XORI, OP_ANDNI: begin
                // Function taken from the opcode's low bits
                eRegWrt = 1'b1;
                eBSrc   = BSRC_IMM5;
                useFn   = 1'b1;
                fn      = op[1:0];
                eZext   = (op == OP_XORI) || (op == OP_ANDNI);
                eSign   = !eZext;
            end
            OP_BEQZ: begin
                eBSrc = BSRC_IMM8;
                eBr   = 4'b0100;
            end
            OP_ST, OP_LD: begin
                eSign    = 1'b1;
                eBSrc    = BSRC_IMM5;
                eOper    = ALU_ADD;
                eMemWrt  = (op == OP_ST);
                eMemRead = (op == OP_LD);
                eRegWrt  = (op == OP_LD);
                eRegSrc  = (op == OP_LD) ? WB_MEM : WB_ALU;
            end
            OP_RALU: begin
                eRegWrt = 1'b1;
                eSign   = 1'b1;
                eDst    = DST_RD;
                useFn   = 1'b1;
            end
            default: begin
                eNop = 1'b1;
                eIll = 1'b1;
            end
        endcase
        if (useFn) begin
            case (fn)
                2'd0: eOper = ALU_ADD;
                2'd1: {eOper, eInvA, eCin} = {ALU_SUB, 2'b11};
                2'd2: eOper = ALU_XOR;
                default: {eOper, eInvB} = {ALU_ANDN, 1'b1};
            endcase
        end
        case (eDst)
            DST_RT:  eRd = instr[7:5];
            DST_RS:  eRd = instr[10:8];
            DST_RD:  eRd = instr[4:2];
            default: eRd = 3'd7;
        endcase
        eImm5  = eZext ? {11'b0, instr[4:0]} : {{11{instr[4]}}, instr[4:0]};
        eImm8  = eZext ? {8'b0, instr[7:0]} : {{8{instr[7]}}, instr[7:0]};
        eImm11 = {{5{instr[10]}}, instr[10:0]};
        // Taken branch in execute squashes side effects and immediates
        eBt = BrchCnd & IDEX_BranchTaken[2];
        if (eBt) begin
            {eRegWrt, eMemWrt, eMemRead, eJmp} = 4'b0000;
            {eImm5, eImm8, eImm11} = '0;
        end
        eRs = (DMWB_RegWrt && DMWB_RD == instr[10:8]) ? WB : shadow[instr[10:8]];
        eRt = (DMWB_RegWrt && DMWB_RD == instr[7:5]) ? WB : shadow[instr[7:5]];

        checkVal("RegWrt", eRegWrt, RegWrt);
        checkVal("MemWrt", eMemWrt, MemWrt);
        checkVal("MemRead", eMemRead, MemRead);
        checkVal("ALUJmp", eJmp, ALUJmp);
        checkVal("nHaltSig", eHalt, nHaltSig);
        checkVal("NOP", eNop, NOP);
        checkVal("ImmSrc", eImmSrc, ImmSrc);
        checkVal("ALUSign", eSign, ALUSign);
        checkVal("RegSrc", eRegSrc, RegSrc);
        checkVal("BSrc", eBSrc, BSrc);
        checkVal("BranchTaken", eBr, BranchTaken);
        checkVal("Oper", eOper, Oper);
        checkVal("invA", eInvA, invA);
        checkVal("invB", eInvB, invB);
        checkVal("Cin", eCin, Cin);
        checkVal("Rs", instr[10:8], Rs);
        checkVal("Rt", instr[7:5], Rt);
        checkVal("RD", eRd, RD);
        checkVal("RSData", eRs, RSData);
        checkVal("RTData", eRt, RTData);
        checkVal("Imm5", eImm5, Imm5);
        checkVal("Imm8", eImm8, Imm8);
        checkVal("sImm11", eImm11, sImm11);
        checkVal("PC_Next", PC, PC_Next);
        checkVal("NOP_Branch", eBt | eBr[3], NOP_Branch);
        checkVal("err", eIll | IDF_err, err);
    endtask

    // Inputs change on the rising edge, so compare on the falling one
    always @(negedge clk) begin
        if (started) begin
            checkVal("valid", expValid, valid);
            if (!rst) begin
                checkOutputs();
            end
        end
    end

endmodule

`default_nettype wire

// File: bench/clockGen.sv
// ==========================================================================
// Testbench clock and reset
// 40 ns clock, synchronous reset held high for the first 8 cycles
// ==========================================================================
`default_nettype none
`timescale 1ns/100ps

module clockGen (
    output logic clk,
    output logic rst
);

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

    always #HALF_PERIOD clk = ~clk;

endmodule

`default_nettype wire

// File: rtl/decode.sv
// ==========================================================================
// Decode stage
// Decodes the fetched word into controls, operands and immediates, reads
// the register file, cancels side effects behind a taken branch and
// forces a no-op on hazard request
// ==========================================================================
`default_nettype none
`timescale 1ns/100ps

module decode (
    input  wire                          clk,
    input  wire                          rst,
    input  wire  [isaPkg::DATA_W-1:0]    instr,
    input  wire  [isaPkg::DATA_W-1:0]    WB,
    input  wire  [isaPkg::DATA_W-1:0]    PC,
    input  wire                          NOP_mech,
    input  wire                          IDF_err,
    input  wire  [isaPkg::REG_W-1:0]     DMWB_RD,
    input  wire                          DMWB_RegWrt,
    input  wire                          BrchCnd,
    input  wire  [ctrlPkg::BR_W-1:0]     IDEX_BranchTaken,
    output logic                         nHaltSig,
    output logic                         MemRead,
    output logic                         MemWrt,
    output logic                         RegWrt,
    output logic                         ALUJmp,
    output logic                         ImmSrc,
    output logic                         ALUSign,
    output logic [ctrlPkg::SEL_W-1:0]    RegSrc,
    output logic [ctrlPkg::SEL_W-1:0]    BSrc,
    output logic [ctrlPkg::BR_W-1:0]     BranchTaken,
    output logic [ctrlPkg::ALUOP_W-1:0]  Oper,
    output logic                         invA,
    output logic                         invB,
    output logic                         Cin,
    output logic [isaPkg::DATA_W-1:0]    RSData,
    output logic [isaPkg::DATA_W-1:0]    RTData,
    output logic [isaPkg::REG_W-1:0]     Rs,
    output logic [isaPkg::REG_W-1:0]     Rt,
    output logic [isaPkg::REG_W-1:0]     RD,
    output logic [isaPkg::DATA_W-1:0]    Imm5,
    output logic [isaPkg::DATA_W-1:0]    Imm8,
    output logic [isaPkg::DATA_W-1:0]    sImm11,
    output logic [isaPkg::DATA_W-1:0]    PC_Next,
    output logic                         NOP,
    output logic                         NOP_Branch,
    output logic                         valid,
    output logic                         err
);

    import isaPkg::*;
    import ctrlPkg::*;

    instrWord_t          instrU;
    logic [OPCODE_W-1:0] ctrlOpcode;
    logic                ctrlRegWrt;
    logic                ctrlMemWrt;
    logic                ctrlMemRead;
    logic                ctrlAluJmp;
    logic                zeroExt;
    logic                illegal;
    logic [SEL_W-1:0]    regDst;
    logic [CLS_W-1:0]    aluClass;
    logic [FUNC_W-1:0]   aluFunc;
    logic                bt;
    logic [DATA_W-1:0]   ext5;
    logic [DATA_W-1:0]   ext8;

    assign instrU = instr;

    // Hazard logic swaps in a nop opcode
    assign ctrlOpcode = NOP_mech ? OP_NOP : instrU.iForm.opcode;

    control u_control (
        .opcode      (ctrlOpcode),
        .RegWrt      (ctrlRegWrt),
        .MemWrt      (ctrlMemWrt),
        .MemRead     (ctrlMemRead),
        .ALUJmp      (ctrlAluJmp),
        .nHaltSig    (nHaltSig),
        .NOP         (NOP),
        .ZeroExt     (zeroExt),
        .ImmSrc      (ImmSrc),
        .ALUSign     (ALUSign),
        .RegDst      (regDst),
        .BSrc        (BSrc),
        .RegSrc      (RegSrc),
        .BranchTaken (BranchTaken),
        .aluClass    (aluClass),
        .illegal     (illegal)
    );

    // Immediate ALU ops carry their function in the opcode's low bits
    assign aluFunc = (aluClass == CLS_IMM) ? ctrlOpcode[FUNC_W-1:0] : instrU.rForm.func;

    aluControl u_aluControl (
        .aluClass (aluClass),
        .func     (aluFunc),
        .Oper     (Oper),
        .invA     (invA),
        .invB     (invB),
        .Cin      (Cin)
    );

    assign Rs = instrU.iForm.rs;
    assign Rt = instrU.iForm.rt;

    regFileBypass u_regFile (
        .clk         (clk),
        .rst         (rst),
        .read1RegSel (Rs),
        .read2RegSel (Rt),
        .writeRegSel (DMWB_RD),
        .writeData   (WB),
        .writeEn     (DMWB_RegWrt),
        .read1Data   (RSData),
        .read2Data   (RTData)
    );

    always_comb begin
        case (regDst)
            DST_RT:  RD = instrU.iForm.rt;
            DST_RS:  RD = instrU.iForm.rs;
            DST_RD:  RD = instrU.rForm.rd;
            default: RD = 3'd7;
        endcase
    end

    // Taken branch in execute squashes this instruction
    assign bt         = BrchCnd & IDEX_BranchTaken[BR_COND_BIT];
    assign NOP_Branch = bt | BranchTaken[BR_JUMP_BIT];

    assign RegWrt  = bt ? 1'b0 : ctrlRegWrt;
    assign MemWrt  = bt ? 1'b0 : ctrlMemWrt;
    assign MemRead = bt ? 1'b0 : ctrlMemRead;
    assign ALUJmp  = bt ? 1'b0 : ctrlAluJmp;

    assign ext5 = zeroExt ? {{(DATA_W-IMM5_W){1'b0}}, instrU.iForm.imm}
                          : {{(DATA_W-IMM5_W){instrU.iForm.imm[IMM5_W-1]}}, instrU.iForm.imm};
    assign ext8 = zeroExt ? {{(DATA_W-IMM8_W){1'b0}}, instr[IMM8_W-1:0]}
                          : {{(DATA_W-IMM8_W){instr[IMM8_W-1]}}, instr[IMM8_W-1:0]};

    assign Imm5   = bt ? '0 : ext5;
    assign Imm8   = bt ? '0 : ext8;
    assign sImm11 = bt ? '0 : {{(DATA_W-IMM11_W){instr[IMM11_W-1]}}, instr[IMM11_W-1:0]};

    assign PC_Next = PC;
    assign err     = illegal | IDF_err;

    // Low through reset and the first cycle after it
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
        end else begin
            valid <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: rtl/regFileBypass.sv
// ==========================================================================
// Register file with bypass
// Eight 16-bit registers, two read ports and one write port; a write in
// the current cycle is forwarded straight to a matching read
// ==========================================================================
`default_nettype none
`timescale 1ns/100ps

module regFileBypass (
    input  wire                       clk,
    input  wire                       rst,
    input  wire  [isaPkg::REG_W-1:0]  read1RegSel,
    input  wire  [isaPkg::REG_W-1:0]  read2RegSel,
    input  wire  [isaPkg::REG_W-1:0]  writeRegSel,
    input  wire  [isaPkg::DATA_W-1:0] writeData,
    input  wire                       writeEn,
    output logic [isaPkg::DATA_W-1:0] read1Data,
    output logic [isaPkg::DATA_W-1:0] read2Data
);

    import isaPkg::*;

    logic [DATA_W-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn) begin
            regs[writeRegSel] <= writeData;
        end
    end

    // Write-to-read forwarding, R0 included
    always_comb begin
        read1Data = regs[read1RegSel];
        read2Data = regs[read2RegSel];
        if (writeEn && (writeRegSel == read1RegSel)) begin
            read1Data = writeData;
        end
        if (writeEn && (writeRegSel == read2RegSel)) begin
            read2Data = writeData;
        end
    end

endmodule

`default_nettype wire

// File: rtl/aluControl.sv
// ==========================================================================
// ALU control
// Turns the decoder's ALU class and a 2-bit function code into the ALU
// operation with its operand invert and carry-in bits
// ==========================================================================
`default_nettype none
`timescale 1ns/100ps

module aluControl (
    input  wire  [ctrlPkg::CLS_W-1:0]   aluClass,
    input  wire  [isaPkg::FUNC_W-1:0]   func,
    output logic [ctrlPkg::ALUOP_W-1:0] Oper,
    output logic                        invA,
    output logic                        invB,
    output logic                        Cin
);

    import ctrlPkg::*;

    always_comb begin
        Oper = ALU_PASS;
        invA = 1'b0;
        invB = 1'b0;
        Cin  = 1'b0;

        case (aluClass)
            CLS_IMM, CLS_REG: begin
                case (func)
                    2'b00: Oper = ALU_ADD;
                    2'b01: begin
                        // rt - rs as ~rs + rt + 1
                        Oper = ALU_SUB;
                        invA = 1'b1;
                        Cin  = 1'b1;
                    end
                    2'b10: Oper = ALU_XOR;
                    default: begin
                        Oper = ALU_ANDN;
                        invB = 1'b1;
                    end
                endcase
            end
            CLS_ADDR: Oper = ALU_ADD;
            default:  Oper = ALU_PASS;
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/control.sv
// ==========================================================================
// Main decoder
// Maps the 5-bit opcode to the control bundle of the decode stage and
// flags opcodes outside the supported subset
// ==========================================================================
`default_nettype none
`timescale 1ns/100ps

module control (
    input  wire  [isaPkg::OPCODE_W-1:0] opcode,
    output logic                        RegWrt,
    output logic                        MemWrt,
    output logic                        MemRead,
    output logic                        ALUJmp,
    output logic                        nHaltSig,
    output logic                        NOP,
    output logic                        ZeroExt,
    output logic                        ImmSrc,
    output logic                        ALUSign,
    output logic [ctrlPkg::SEL_W-1:0]   RegDst,
    output logic [ctrlPkg::SEL_W-1:0]   BSrc,
    output logic [ctrlPkg::SEL_W-1:0]   RegSrc,
    output logic [ctrlPkg::BR_W-1:0]    BranchTaken,
    output logic [ctrlPkg::CLS_W-1:0]   aluClass,
    output logic                        illegal
);

    import isaPkg::*;
    import ctrlPkg::*;

    always_comb begin
        // Idle row, each opcode overrides what it needs
        RegWrt      = 1'b0;
        MemWrt      = 1'b0;
        MemRead     = 1'b0;
        ALUJmp      = 1'b0;
        nHaltSig    = 1'b1;
        NOP         = 1'b0;
        ZeroExt     = 1'b0;
        ImmSrc      = 1'b0;
        ALUSign     = 1'b0;
        RegDst      = DST_RT;
        BSrc        = BSRC_REG;
        RegSrc      = WB_ALU;
        BranchTaken = BR_NONE;
        aluClass    = CLS_NONE;
        illegal     = 1'b0;

        case (opcode)
            OP_HALT: begin
                nHaltSig = 1'b0;
            end
            OP_NOP: begin
                NOP = 1'b1;
            end
            OP_J: begin
                ALUJmp      = 1'b1;
                ImmSrc      = 1'b1;
                BSrc        = BSRC_IMM11;
                BranchTaken = BR_JUMP;
            end
            OP_JAL: begin
                ALUJmp      = 1'b1;
                ImmSrc      = 1'b1;
                BSrc        = BSRC_IMM11;
                BranchTaken = BR_JUMP;
                RegWrt      = 1'b1;
                RegDst      = DST_R7;
                RegSrc      = WB_PC;
            end
            OP_ADDI, OP_SUBI: begin
                RegWrt   = 1'b1;
                ALUSign  = 1'b1;
                BSrc     = BSRC_IMM5;
                aluClass = CLS_IMM;
            end
            OP_XORI, OP_ANDNI: begin
                // Logical immediates take a zero-extended operand
                RegWrt   = 1'b1;
                ZeroExt  = 1'b1;
                BSrc     = BSRC_IMM5;
                aluClass = CLS_IMM;
            end
            OP_BEQZ: begin
                BSrc        = BSRC_IMM8;
                BranchTaken = BR_COND;
            end
            OP_ST: begin
                MemWrt   = 1'b1;
                ALUSign  = 1'b1;
                BSrc     = BSRC_IMM5;
                aluClass = CLS_ADDR;
            end
            OP_LD: begin
                MemRead  = 1'b1;
                RegWrt   = 1'b1;
                ALUSign  = 1'b1;
                BSrc     = BSRC_IMM5;
                RegSrc   = WB_MEM;
                aluClass = CLS_ADDR;
            end
            OP_RALU: begin
                RegWrt   = 1'b1;
                ALUSign  = 1'b1;
                RegDst   = DST_RD;
                aluClass = CLS_REG;
            end
            default: begin
                // Behaves as nop but reports the bad opcode
                NOP     = 1'b1;
                illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/ctrlPkg.sv
// ==========================================================================
// Control encodings for the decode stage
// ALU operations, ALU classes and the operand and write-back selects
// ==========================================================================
`default_nettype none

package ctrlPkg;

    localparam int ALUOP_W = 4;
    localparam int CLS_W   = 2;
    localparam int SEL_W   = 2;
    localparam int BR_W    = 4;

    localparam logic [ALUOP_W-1:0] ALU_ADD  = 4'h0;
    localparam logic [ALUOP_W-1:0] ALU_SUB  = 4'h1;
    localparam logic [ALUOP_W-1:0] ALU_XOR  = 4'h2;
    localparam logic [ALUOP_W-1:0] ALU_ANDN = 4'h3;
    localparam logic [ALUOP_W-1:0] ALU_PASS = 4'h4;

    // Decoder to aluControl
    localparam logic [CLS_W-1:0] CLS_IMM  = 2'd0;
    localparam logic [CLS_W-1:0] CLS_REG  = 2'd1;
    localparam logic [CLS_W-1:0] CLS_ADDR = 2'd2;
    localparam logic [CLS_W-1:0] CLS_NONE = 2'd3;

    // Destination register: bits 7:5, 10:8, 4:2 or R7
    localparam logic [SEL_W-1:0] DST_RT = 2'd0;
    localparam logic [SEL_W-1:0] DST_RS = 2'd1;
    localparam logic [SEL_W-1:0] DST_RD = 2'd2;
    localparam logic [SEL_W-1:0] DST_R7 = 2'd3;

    localparam logic [SEL_W-1:0] BSRC_REG   = 2'd0;
    localparam logic [SEL_W-1:0] BSRC_IMM5  = 2'd1;
    localparam logic [SEL_W-1:0] BSRC_IMM8  = 2'd2;
    localparam logic [SEL_W-1:0] BSRC_IMM11 = 2'd3;

    localparam logic [SEL_W-1:0] WB_ALU = 2'd0;
    localparam logic [SEL_W-1:0] WB_MEM = 2'd1;
    localparam logic [SEL_W-1:0] WB_PC  = 2'd2;

    // Branch code bits
    localparam int BR_COND_BIT = 2;
    localparam int BR_JUMP_BIT = 3;
    localparam logic [BR_W-1:0] BR_NONE = 4'b0000;
    localparam logic [BR_W-1:0] BR_COND = 4'b0100;
    localparam logic [BR_W-1:0] BR_JUMP = 4'b1000;

endpackage

`default_nettype wire

// File: rtl/isaPkg.sv
// ==========================================================================
// Instruction-set encoding for the 16-bit decode stage
// Opcodes, field widths and the two views of an instruction word
// ==========================================================================
`default_nettype none

package isaPkg;

    localparam int OPCODE_W = 5;
    localparam int REG_W    = 3;
    localparam int DATA_W   = 16;
    localparam int NUM_REGS = 8;
    localparam int IMM5_W   = 5;
    localparam int IMM8_W   = 8;
    localparam int IMM11_W  = 11;
    localparam int FUNC_W   = 2;

    // Supported opcodes, everything else is illegal
    localparam logic [OPCODE_W-1:0] OP_HALT  = 5'b00000;
    localparam logic [OPCODE_W-1:0] OP_NOP   = 5'b00001;
    localparam logic [OPCODE_W-1:0] OP_J     = 5'b00100;
    localparam logic [OPCODE_W-1:0] OP_JAL   = 5'b00110;
    localparam logic [OPCODE_W-1:0] OP_ADDI  = 5'b01000;
    localparam logic [OPCODE_W-1:0] OP_SUBI  = 5'b01001;
    localparam logic [OPCODE_W-1:0] OP_XORI  = 5'b01010;
    localparam logic [OPCODE_W-1:0] OP_ANDNI = 5'b01011;
    localparam logic [OPCODE_W-1:0] OP_BEQZ  = 5'b01100;
    localparam logic [OPCODE_W-1:0] OP_ST    = 5'b10000;
    localparam logic [OPCODE_W-1:0] OP_LD    = 5'b10001;
    localparam logic [OPCODE_W-1:0] OP_RALU  = 5'b11011;

    // Same 16 bits seen as immediate format or register format
    typedef union packed {
        struct packed {
            logic [OPCODE_W-1:0] opcode;
            logic [REG_W-1:0]    rs;
            logic [REG_W-1:0]    rt;
            logic [IMM5_W-1:0]   imm;
        } iForm;
        struct packed {
            logic [OPCODE_W-1:0] opcode;
            logic [REG_W-1:0]    rs;
            logic [REG_W-1:0]    rt;
            logic [REG_W-1:0]    rd;
            logic [FUNC_W-1:0]   func;
        } rForm;
    } instrWord_t;

endpackage

`default_nettype wire
